//--- common/exec_types_pkg.sv
// exec types: operand, product and tag widths shared across the complex execute lane
package exec_types_pkg;

  // datapath widths
  localparam int unsigned DATA_W  = 32;         // one machine word
  localparam int unsigned DWORD_W = 2 * DATA_W; // full multiply product
  localparam int unsigned TAG_W   = 7;          // physical reg tag, 128 entries

  // one operand or one writeback result
  typedef logic [DATA_W-1:0] data_t;

  // double word, holds the whole product before half select
  typedef logic [DWORD_W-1:0] dword_t;

  // destination physical register tag
  typedef logic [TAG_W-1:0] tag_t;

  // most negative signed word
  // the only dividend that can overflow a signed divide
  localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  // all ones word
  // divide by zero quotient, also minus one as a divisor
  localparam data_t DATA_ONES = {DATA_W{1'b1}};

  // zero word
  // result of syscall and illegal ops
  localparam data_t DATA_ZERO = {DATA_W{1'b0}};

  // unit word, substituted for a divisor that would trap
  localparam data_t DATA_ONE = {{(DATA_W-1){1'b0}}, 1'b1};

endpackage : exec_types_pkg

//--- common/complex_op_pkg.sv
// complex op definitions: opcode encoding, execution flags and lane packet formats
package complex_op_pkg;

  import exec_types_pkg::*;

  // complex unit opcodes, codes 9 to 15 are illegal
  typedef enum logic [3:0] {
    OP_MULT_L  = 4'h0, // signed product, low word
    OP_MULT_H  = 4'h1, // signed product, high word
    OP_MULTU_L = 4'h2, // unsigned product, low word
    OP_MULTU_H = 4'h3, // unsigned product, high word
    OP_DIV     = 4'h4, // signed quotient
    OP_REM     = 4'h5, // signed remainder
    OP_DIVU    = 4'h6, // unsigned quotient
    OP_REMU    = 4'h7, // unsigned remainder
    OP_SYSCALL = 4'h8  // trap to the os, no result
  } complex_op_e;

  // completion flags returned with every writeback
  typedef struct packed {
    logic executed;  // instruction went through the unit
    logic exception; // syscall or illegal op, retire must trap
    logic hi_half;   // result is the upper product word
  } exec_flags_t;

  // issued instruction as seen by the lane
  typedef struct packed {
    logic        valid; // single cycle strobe
    tag_t        tag;   // destination physical reg
    complex_op_e op;
    data_t       src1;
    data_t       src2;
  } issue_pkt_t;

  // completed instruction back to the writeback bus
  typedef struct packed {
    logic        valid;
    tag_t        tag;
    data_t       result;
    exec_flags_t flags;
  } wb_pkt_t;

endpackage : complex_op_pkg

//--- complex_fu/complex_alu.sv
// complex alu: combinational multiply, divide, remainder and syscall evaluation with flags
`timescale 1ns/10ps

module complex_alu
  import exec_types_pkg::*;
  import complex_op_pkg::*;
(
  input  complex_op_e op_i,
  input  data_t       src1_i,
  input  data_t       src2_i,
  output data_t       result_o,
  output exec_flags_t flags_o
);

  // signed views of the operands
  logic signed [DATA_W-1:0] src1_s;
  logic signed [DATA_W-1:0] src2_s;

  // full products
  logic signed [DWORD_W-1:0] prod_s; // sign extended by context width
  dword_t                    prod_u; // zero extended

  // divide corner detection
  logic div_zero; // divisor is zero, both signednesses
  logic div_ovf;  // min / -1, signed only

  // guarded divisors so the raw divider never sees a trap case
  logic signed [DATA_W-1:0] divs_s;
  data_t                    divs_u;

  // raw divider outputs
  logic signed [DATA_W-1:0] quot_s;
  logic signed [DATA_W-1:0] rem_s;
  data_t                    quot_u;
  data_t                    rem_u;

  // corner-resolved divide results
  data_t div_res;
  data_t rem_res;
  data_t divu_res;
  data_t remu_res;

  assign src1_s = src1_i;
  assign src2_s = src2_i;

  // 32x32 -> 64 multipliers
  assign prod_s = src1_s * src2_s;
  assign prod_u = src1_i * src2_i;

  assign div_zero = (src2_i == DATA_ZERO);
  assign div_ovf  = (src1_i == DATA_MIN) && (src2_i == DATA_ONES);

  // dividing by one on overflow already gives quotient min, remainder zero
  assign divs_s = (div_zero || div_ovf) ? DATA_ONE : src2_s;
  assign divs_u = div_zero ? DATA_ONE : src2_i;

  assign quot_s = src1_s / divs_s;
  assign rem_s  = src1_s % divs_s; // sign follows the dividend
  assign quot_u = src1_i / divs_u;
  assign rem_u  = src1_i % divs_u;

  // divide by zero: quotient all ones, remainder is the dividend
  assign div_res  = div_zero ? DATA_ONES : data_t'(quot_s);
  assign rem_res  = div_zero ? src1_i    : data_t'(rem_s);
  assign divu_res = div_zero ? DATA_ONES : quot_u;
  assign remu_res = div_zero ? src1_i    : rem_u;

  always_comb begin
    result_o          = DATA_ZERO;
    flags_o.executed  = 1'b1; // every op passes through the unit
    flags_o.exception = 1'b0;
    flags_o.hi_half   = 1'b0;

    case (op_i)
      OP_MULT_L: begin
        result_o = prod_s[DATA_W-1:0];
      end
      OP_MULT_H: begin
        result_o        = prod_s[DWORD_W-1:DATA_W];
        flags_o.hi_half = 1'b1;
      end
      OP_MULTU_L: begin
        result_o = prod_u[DATA_W-1:0];
      end
      OP_MULTU_H: begin
        result_o        = prod_u[DWORD_W-1:DATA_W];
        flags_o.hi_half = 1'b1;
      end
      OP_DIV:  result_o = div_res;
      OP_REM:  result_o = rem_res;
      OP_DIVU: result_o = divu_res;
      OP_REMU: result_o = remu_res;
      OP_SYSCALL: begin
        flags_o.exception = 1'b1; // handed to the os at retire
      end
      default: begin
        // illegal encoding, zero result and trap
        flags_o.exception = 1'b1;
      end
    endcase
  end

endmodule : complex_alu

//--- complex_fu/complex_fu_pipe.sv
// complex fu pipe: fixed depth result pipeline for valid, tag, result and flags with flush
`timescale 1ns/10ps

module complex_fu_pipe
  import exec_types_pkg::*;
  import complex_op_pkg::*;
#(
  parameter int unsigned LATENCY = 3 // register stages, 1 or more
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        flush_i,   // level, squashes everything in flight
  input  logic        valid_i,
  input  tag_t        tag_i,
  input  data_t       result_i,
  input  exec_flags_t flags_i,
  output wb_pkt_t     wb_o
);

  // a zero depth pipe would break the fixed writeback slot
  if (LATENCY < 1) begin : g_bad_latency
    $error("complex_fu_pipe needs LATENCY of at least 1");
  end

  wb_pkt_t stage_d;              // packet entering stage 0
  wb_pkt_t stage_q [LATENCY];    // stage 0 is youngest
  logic    squash;               // clear all stage valids

  // pack the alu outputs with the issue tag
  always_comb begin
    stage_d.valid  = valid_i;
    stage_d.tag    = tag_i;
    stage_d.result = result_i;
    stage_d.flags  = flags_i;
  end

  // flush also kills this cycle's issue since stage 0 is cleared too
  assign squash = rst_i || flush_i;

  always_ff @(posedge clk) begin
    // payload shifts every cycle, only the valid bits matter for control
    stage_q[0].tag    <= stage_d.tag;
    stage_q[0].result <= stage_d.result;
    stage_q[0].flags  <= stage_d.flags;
    for (int i = 1; i < LATENCY; i++) begin
      stage_q[i].tag    <= stage_q[i-1].tag;
      stage_q[i].result <= stage_q[i-1].result;
      stage_q[i].flags  <= stage_q[i-1].flags;
    end

    // valid chain
    if (squash) begin
      for (int i = 0; i < LATENCY; i++) begin
        stage_q[i].valid <= 1'b0;
      end
    end else begin
      stage_q[0].valid <= stage_d.valid;
      for (int i = 1; i < LATENCY; i++) begin
        stage_q[i].valid <= stage_q[i-1].valid; // no stall, always advances
      end
    end
  end

  // oldest stage goes straight onto the writeback bus
  assign wb_o = stage_q[LATENCY-1];

endmodule : complex_fu_pipe

//--- logic/complex_exec_top.sv
// complex exec top: execute lane joining the complex alu to its result pipeline
`timescale 1ns/10ps

module complex_exec_top
  import exec_types_pkg::*;
  import complex_op_pkg::*;
#(
  parameter int unsigned LATENCY = 3 // issue to writeback, in cycles
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       flush_i,
  input  issue_pkt_t issue_i,
  output wb_pkt_t    wb_o
);

  data_t       alu_result; // same cycle as issue
  exec_flags_t alu_flags;

  // evaluated every cycle, the valid bit qualifies it in the pipe
  complex_alu u_alu (
    .op_i     (issue_i.op),
    .src1_i   (issue_i.src1),
    .src2_i   (issue_i.src2),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  complex_fu_pipe #(
    .LATENCY (LATENCY)
  ) u_pipe (
    .clk      (clk),
    .rst_i    (rst_i),
    .flush_i  (flush_i),
    .valid_i  (issue_i.valid),
    .tag_i    (issue_i.tag),
    .result_i (alu_result),
    .flags_i  (alu_flags),
    .wb_o     (wb_o)
  );

endmodule : complex_exec_top

//--- tb/complex_fu_asserts.sv
// complex fu asserts: bound checks on result pipeline valid timing and flush squash
`timescale 1ns/10ps

module complex_fu_asserts
  import complex_op_pkg::*;
#(
  parameter int unsigned LATENCY = 3 // must match the bound pipe
) (
  input logic    clk,
  input logic    rst_i,
  input logic    flush_i,
  input logic    valid_i,
  input wb_pkt_t wb_i    // the pipe's writeback bus
);

  // pipe leaves reset empty
  a_reset_empty: assert property (@(posedge clk) rst_i |=> !wb_i.valid)
    else $error("wb valid high in the cycle after reset");

  // every writeback had its issue exactly LATENCY edges back
  a_valid_timing: assert property (@(posedge clk) disable iff (rst_i)
    wb_i.valid |-> $past(valid_i, LATENCY))
    else $error("writeback without an issue LATENCY cycles earlier");

  // anything leaving now was issued before a flush seen in the last LATENCY edges
  for (genvar n = 1; n <= LATENCY; n++) begin : g_flush
    a_flush_squash: assert property (@(posedge clk) disable iff (rst_i)
      wb_i.valid |-> !$past(flush_i, n))
      else $error("writeback survived a flush %0d cycles back", n);
  end

endmodule : complex_fu_asserts

bind complex_fu_pipe complex_fu_asserts #(
  .LATENCY (LATENCY)
) u_asserts (
  .clk     (clk),
  .rst_i   (rst_i),
  .flush_i (flush_i),
  .valid_i (valid_i),
  .wb_i    (wb_o)
);

//--- tb/tb_complex_exec.sv
// complex exec testbench: random and directed issue stream checked against a reference model
`timescale 1ns/10ps

module tb_complex_exec
  import exec_types_pkg::*;
  import complex_op_pkg::*;
();

  localparam int unsigned LATENCY    = 3;
  localparam int unsigned RST_CYCLES = 16;
  localparam int unsigned N_RANDOM   = 450; // sparse random issues
  localparam int unsigned N_STREAM   = 300; // one issue every cycle
  localparam int unsigned N_MIXED    = 250; // random with sparse flushes
  localparam int unsigned TIMEOUT    = 1500; // ~1000 issue cycles plus drain and margin

  // expected result and flags of one op
  typedef struct packed {
    data_t       result;
    exec_flags_t flags;
  } ref_t;

  // one in-flight instruction
  typedef struct packed {
    tag_t        tag;
    data_t       result;
    exec_flags_t flags;
    logic [31:0] stamp; // cycle of the issue edge
  } exp_t;

  logic        clk = 1'b0;
  logic        rst_i;
  logic        flush_i;
  issue_pkt_t  issue_i;
  wb_pkt_t     wb_o;

  int unsigned cycle = 0;
  exp_t        exp_q[$];
  tag_t        next_tag = '0;
  logic [31:0] lcg_state = 32'hc189;

  complex_exec_top #(
    .LATENCY (LATENCY)
  ) dut (
    .clk     (clk),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .issue_i (issue_i),
    .wb_o    (wb_o)
  );

  always #4 clk = ~clk; // 8 ns period

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic data_t rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]}; // upper lcg bits only
  endfunction

  // mostly random, some small signed values, ~1 in 10 a corner
  function automatic data_t pick_operand();
    logic [31:0] sel;
    logic [31:0] kind;
    data_t       w;
    sel  = lcg_next() >> 16;
    kind = (lcg_next() >> 16) % 3;
    w    = rand_word();
    if (sel % 10 == 0) begin
      case (kind)
        0:       return 32'h0000_0000;
        1:       return 32'hffff_ffff;
        default: return 32'h8000_0000;
      endcase
    end else if (sel % 10 < 3) begin
      return {{24{w[7]}}, w[7:0]}; // gives divides a real quotient
    end
    return w;
  endfunction

  function automatic complex_op_e pick_op();
    logic [31:0] r;
    r = lcg_next();
    if (r[31:28] == 4'h0) begin
      return complex_op_e'(r[19:16]); // any code, illegal ones too
    end
    return complex_op_e'(4'(r[27:16] % 9));
  endfunction

  // reference model of every opcode with its divide corner rules
  function automatic ref_t ref_complex(complex_op_e op, data_t a, data_t b);
    ref_t            res;
    int              sa;
    int              sb;
    longint          sp;
    longint unsigned up;
    logic            ovf;
    sa  = a;
    sb  = b;
    sp  = longint'(sa) * longint'(sb);
    up  = longint'({32'd0, a}) * longint'({32'd0, b});
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff); // min / -1
    res.result          = '0;
    res.flags.executed  = 1'b1;
    res.flags.exception = 1'b0;
    res.flags.hi_half   = 1'b0;
    case (op)
      OP_MULT_L:  res.result = sp[31:0];
      OP_MULT_H:  begin
        res.result        = sp[63:32];
        res.flags.hi_half = 1'b1;
      end
      OP_MULTU_L: res.result = up[31:0];
      OP_MULTU_H: begin
        res.result        = up[63:32];
        res.flags.hi_half = 1'b1;
      end
      OP_DIV:  res.result = (b == 0) ? 32'hffff_ffff : (ovf ? a : data_t'(sa / sb));
      OP_REM:  res.result = (b == 0) ? a : (ovf ? 32'h0 : data_t'(sa % sb));
      OP_DIVU: res.result = (b == 0) ? 32'hffff_ffff : a / b;
      OP_REMU: res.result = (b == 0) ? a : a % b;
      OP_SYSCALL: res.flags.exception = 1'b1;
      default:    res.flags.exception = 1'b1; // illegal code
    endcase
    return res;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_result(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flags(input string name, input exec_flags_t got, input exec_flags_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // one falling edge of stimulus, the expected entry goes in only if it survives
  task automatic issue_cycle(input logic valid, input complex_op_e op, input data_t a,
                             input data_t b, input logic flush);
    ref_t expv;
    exp_t ent;
    @(negedge clk);
    issue_i.valid = valid;
    issue_i.tag   = next_tag;
    issue_i.op    = op;
    issue_i.src1  = a;
    issue_i.src2  = b;
    flush_i       = flush;
    if (valid && !flush) begin
      expv       = ref_complex(op, a, b);
      ent.tag    = next_tag;
      ent.result = expv.result;
      ent.flags  = expv.flags;
      ent.stamp  = cycle; // equals the count seen at the issue edge
      exp_q.push_back(ent);
    end
    if (valid) next_tag = next_tag + 1'b1;
  endtask

  task automatic issue_random(input logic valid, input logic flush);
    complex_op_e op;
    data_t       a;
    data_t       b;
    op = pick_op();
    a  = pick_operand();
    b  = pick_operand();
    issue_cycle(valid, op, a, b, flush); // junk payload when not valid
  endtask

  task automatic idle_cycle();
    issue_cycle(1'b0, OP_MULT_L, '0, '0, 1'b0);
  endtask

  // cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) stop_on_error("timeout: writebacks never drained");
  end

  // compare writebacks against the head of the queue
  always @(posedge clk) begin : compare
    exp_t head;
    if (!rst_i) begin
      if (wb_o.valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          stop_on_error("writeback valid with no instruction in flight");
        end else begin
          head = exp_q.pop_front();
          if (cycle != head.stamp + LATENCY) begin
            stop_on_error($sformatf("tag %0d written back at cycle %0d but issued at %0d",
                                    head.tag, cycle, head.stamp));
          end
          check_tag("wb_o.tag", wb_o.tag, head.tag);
          check_result("wb_o.result", wb_o.result, head.result);
          check_flags("wb_o.flags", wb_o.flags, head.flags);
        end
      end else if (wb_o.valid !== 1'b0) begin
        stop_on_error("wb_o.valid is unknown after reset");
      end else if (exp_q.size() != 0 && exp_q[0].stamp + LATENCY <= cycle) begin
        stop_on_error($sformatf("writeback missing for tag %0d", exp_q[0].tag));
      end
      if (flush_i) exp_q.delete(); // everything still in flight is squashed
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    rst_i   = 1'b1;
    flush_i = 1'b0;
    issue_i = '0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_i = 1'b0;
    repeat (8) idle_cycle(); // nothing may come out yet

    // directed corners, back to back
    issue_cycle(1'b1, OP_DIV,     32'h8000_0000, 32'hffff_ffff, 1'b0);
    issue_cycle(1'b1, OP_REM,     32'h8000_0000, 32'hffff_ffff, 1'b0);
    issue_cycle(1'b1, OP_DIV,     32'hffff_fff9, 32'h0000_0000, 1'b0);
    issue_cycle(1'b1, OP_REM,     32'hffff_fff9, 32'h0000_0000, 1'b0);
    issue_cycle(1'b1, OP_DIVU,    32'h0000_0005, 32'h0000_0000, 1'b0);
    issue_cycle(1'b1, OP_REMU,    32'h0000_0005, 32'h0000_0000, 1'b0);
    issue_cycle(1'b1, OP_DIV,     32'hffff_fff9, 32'h0000_0002, 1'b0);
    issue_cycle(1'b1, OP_REM,     32'hffff_fff9, 32'h0000_0002, 1'b0);
    issue_cycle(1'b1, OP_MULT_H,  32'h8000_0000, 32'h8000_0000, 1'b0);
    issue_cycle(1'b1, OP_MULT_H,  32'hffff_ffff, 32'h0000_0001, 1'b0);
    issue_cycle(1'b1, OP_MULTU_H, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    issue_cycle(1'b1, OP_MULT_L,  32'hffff_fffd, 32'h0000_0005, 1'b0);
    issue_cycle(1'b1, OP_SYSCALL, 32'h1234_5678, 32'h9abc_def0, 1'b0);
    issue_cycle(1'b1, complex_op_e'(4'h9), 32'h1, 32'h2, 1'b0);
    issue_cycle(1'b1, complex_op_e'(4'hf), 32'h3, 32'h4, 1'b0);

    repeat (N_RANDOM) begin
      r = lcg_next();
      issue_random(r[31:30] != 2'b00, 1'b0); // ~3 of 4 cycles
    end

    // full rate stream, flushed twice with a live issue on the flush cycle
    for (int i = 0; i < N_STREAM; i++) begin
      issue_random(1'b1, i == 100 || i == 217);
    end

    repeat (N_MIXED) begin
      r = lcg_next();
      issue_random(r[31], r[30:25] == 6'd0);
    end

    while (exp_q.size() != 0) idle_cycle();
    repeat (LATENCY + 4) idle_cycle();
    $display("All tests passed");
    $finish;
  end

endmodule : tb_complex_exec

//--- sources.f
common/exec_types_pkg.sv
common/complex_op_pkg.sv
complex_fu/complex_alu.sv
complex_fu/complex_fu_pipe.sv
logic/complex_exec_top.sv
tb/complex_fu_asserts.sv
tb/tb_complex_exec.sv

//--- Makefile
TOP := tb_complex_exec

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
